// ==== src/rv_pkg.sv ====
/*
  Shared types of the rv32i SoC: word, register index, access types,
  the FSM state enums, the output register address and the opcodes.
*/
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;    // data or byte address
  typedef logic [4:0]  reg_idx_t;

  // 0 none, 1 byte, 2 half word, 3 word
  typedef logic [1:0] wtype_t;

  // low bits size as in wtype_t, bit 2 asks for sign extension
  typedef logic [2:0] rtype_t;

  typedef enum logic [2:0] {
    WAIT_POWER,
    SEND_CMD,
    SEND_ADDR,
    SHIFT,
    READ_BYTES,
    START_WRITE,
    WRITE,
    DONE
  } boot_state_t;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    EXECUTE,
    STORE,
    LOAD,
    LOAD_DONE
  } cpu_state_t;

  localparam word_t IO_ADDR = 32'hFFFF_FFF0;  // output register

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

endpackage

`default_nettype wire

// ==== src/flash_boot.sv ====
/*
  Boot loader: power-up wait, SPI read command 3 from address 0,
  and word writes of the flash image into RAM.
*/
`timescale 1ns/10ps
`default_nettype none

module flash_boot #(
  parameter int unsigned STARTUP_WAIT = 1000000,
  parameter int unsigned BOOT_BYTES   = 1024
) (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          flash_miso,
  input  wire logic          ram_busy,
  output logic               flash_clk,
  output logic               flash_mosi,
  output logic               flash_cs,
  output logic               boot_enable,
  output rv_pkg::wtype_t     boot_write_type,
  output rv_pkg::word_t      boot_address,
  output rv_pkg::word_t      boot_data_in,
  output logic               boot_done
);
  import rv_pkg::*;

  boot_state_t state;
  boot_state_t ret_state;   // where SHIFT goes when done
  word_t       cnt;         // wait cycles, bits left or bits read
  logic        phase;       // 0 clock low, 1 clock high
  logic [23:0] tx_sr;
  logic [7:0]  rx_sr;
  logic [1:0]  byte_cnt;
  word_t       word_buf;    // bytes gathered little-endian
  word_t       next_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state           <= WAIT_POWER;
      ret_state       <= WAIT_POWER;
      cnt             <= '0;
      phase           <= 1'b0;
      byte_cnt        <= '0;
      next_addr       <= '0;
      flash_clk       <= 1'b0;
      flash_mosi      <= 1'b0;
      flash_cs        <= 1'b1;
      boot_enable     <= 1'b0;
      boot_write_type <= '0;
      boot_done       <= 1'b0;
    end else begin
      case (state)
        WAIT_POWER: begin
          if (cnt == STARTUP_WAIT - 1) begin
            cnt   <= '0;
            state <= SEND_CMD;
          end else begin
            cnt <= cnt + 1;
          end
        end
        SEND_CMD: begin
          flash_cs  <= 1'b0;
          tx_sr     <= {8'h03, 16'h0000};  // read command
          cnt       <= 32'd8;
          ret_state <= SEND_ADDR;
          state     <= SHIFT;
        end
        SEND_ADDR: begin
          tx_sr     <= '0;                 // start address 0
          cnt       <= 32'd24;
          ret_state <= READ_BYTES;
          state     <= SHIFT;
        end
        SHIFT: begin
          if (!phase) begin
            flash_clk  <= 1'b0;
            flash_mosi <= tx_sr[23];
            tx_sr      <= {tx_sr[22:0], 1'b0};
            cnt        <= cnt - 1;
            phase      <= 1'b1;
          end else begin
            flash_clk <= 1'b1;
            phase     <= 1'b0;
            if (cnt == 0) state <= ret_state;
          end
        end
        READ_BYTES: begin
          if (!phase) begin
            flash_clk <= 1'b0;             // flash shifts out next bit
            phase     <= 1'b1;
          end else begin
            flash_clk <= 1'b1;
            phase     <= 1'b0;
            rx_sr     <= {rx_sr[6:0], flash_miso};
            cnt       <= cnt + 1;
            if (cnt[2:0] == 3'd7) begin
              word_buf <= {rx_sr[6:0], flash_miso, word_buf[31:8]};
              byte_cnt <= byte_cnt + 1;
              if (byte_cnt == 2'd3) state <= START_WRITE;
            end
          end
        end
        START_WRITE: begin
          if (!ram_busy) begin
            boot_enable     <= 1'b1;
            boot_write_type <= 2'd3;       // word
            boot_address    <= next_addr;
            boot_data_in    <= word_buf;
            next_addr       <= next_addr + 4;
            state           <= WRITE;
          end
        end
        WRITE: begin
          boot_enable <= 1'b0;
          if (next_addr == BOOT_BYTES) begin
            flash_cs  <= 1'b1;
            boot_done <= 1'b1;
            state     <= DONE;
          end else begin
            state <= READ_BYTES;
          end
        end
        default: ;                         // DONE holds
      endcase
    end
  end

  a_boot_no_busy: assert property (@(posedge clk) disable iff (!rst_n)
    boot_enable |-> !ram_busy);

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
/*
  Register file: 32 x 32 bits, x0 reads zero,
  two combinational reads and one clocked write.
*/
`timescale 1ns/10ps
`default_nettype none

module reg_file (
  input  wire logic             clk,
  input  wire rv_pkg::reg_idx_t rs1,
  input  wire rv_pkg::reg_idx_t rs2,
  input  wire rv_pkg::reg_idx_t rd,
  input  wire rv_pkg::word_t    rd_wd,
  input  wire logic             rd_we,
  output rv_pkg::word_t         rs1_dat,
  output rv_pkg::word_t         rs2_dat
);
  import rv_pkg::*;

  word_t regs [32];

  always_ff @(posedge clk) begin
    if (rd_we && rd != 5'd0) begin
      regs[rd] <= rd_wd;
    end
  end

  assign rs1_dat = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_dat = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
/*
  Reduced multicycle RV32I core: fetch, execute, load and store FSM
  with immediate decode, ALU, branch compare and register file.
*/
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire logic          boot_done,
  input  wire rv_pkg::word_t ram_data_out,
  input  wire logic          ram_data_out_ready,
  input  wire logic          ram_busy,
  output logic               cpu_enable,
  output rv_pkg::rtype_t     cpu_read_type,
  output rv_pkg::wtype_t     cpu_write_type,
  output rv_pkg::word_t      cpu_address,
  output rv_pkg::word_t      cpu_data_in
);
  import rv_pkg::*;

  cpu_state_t state;
  word_t      pc;
  word_t      ir;
  word_t      rd_wd;
  logic       rd_we;
  word_t      rs1_dat;
  word_t      rs2_dat;

  logic [6:0] opcode;
  logic [2:0] funct3;
  reg_idx_t   rs1;
  reg_idx_t   rs2;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  word_t      alu_b;
  word_t      alu_res;
  logic       taken;
  word_t      pc_next;
  word_t      wb_val;
  logic       wb_en;

  assign opcode = ir[6:0];
  assign funct3 = ir[14:12];
  assign rs1    = ir[19:15];
  assign rs2    = ir[24:20];
  assign rd     = ir[11:7];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'h000};
  assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};

  // second ALU operand is rs2 or the I immediate
  always_comb begin
    alu_b = (opcode == OP_REG) ? rs2_dat : imm_i;
    case (funct3)
      3'b000: alu_res = (opcode == OP_REG && ir[30]) ? rs1_dat - alu_b : rs1_dat + alu_b;
      3'b001: alu_res = rs1_dat << alu_b[4:0];
      3'b010: alu_res = {31'd0, $signed(rs1_dat) < $signed(alu_b)};
      3'b011: alu_res = {31'd0, rs1_dat < alu_b};
      3'b100: alu_res = rs1_dat ^ alu_b;
      3'b101: begin
        if (ir[30]) alu_res = $signed(rs1_dat) >>> alu_b[4:0];
        else        alu_res = rs1_dat >> alu_b[4:0];
      end
      3'b110: alu_res = rs1_dat | alu_b;
      default: alu_res = rs1_dat & alu_b;
    endcase
  end

  always_comb begin
    case (funct3)
      3'b000:  taken = rs1_dat == rs2_dat;
      3'b001:  taken = rs1_dat != rs2_dat;
      3'b100:  taken = $signed(rs1_dat) < $signed(rs2_dat);
      3'b101:  taken = $signed(rs1_dat) >= $signed(rs2_dat);
      3'b110:  taken = rs1_dat < rs2_dat;
      3'b111:  taken = rs1_dat >= rs2_dat;
      default: taken = 1'b0;
    endcase
  end

  // next pc and write-back value of the instruction in ir
  always_comb begin
    pc_next = pc + 4;
    wb_val  = alu_res;
    wb_en   = 1'b0;
    case (opcode)
      OP_LUI: begin
        wb_val = imm_u;
        wb_en  = 1'b1;
      end
      OP_AUIPC: begin
        wb_val = pc + imm_u;
        wb_en  = 1'b1;
      end
      OP_JAL: begin
        wb_val  = pc + 4;
        wb_en   = 1'b1;
        pc_next = pc + imm_j;
      end
      OP_JALR: begin
        wb_val  = pc + 4;
        wb_en   = 1'b1;
        pc_next = (rs1_dat + imm_i) & ~32'd1;
      end
      OP_BRANCH: if (taken) pc_next = pc + imm_b;
      OP_IMM, OP_REG: wb_en = 1'b1;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= IDLE;
      pc             <= '0;
      rd_we          <= 1'b0;
      cpu_enable     <= 1'b0;
      cpu_read_type  <= '0;
      cpu_write_type <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (boot_done && !ram_busy) begin
            cpu_enable    <= 1'b1;
            cpu_read_type <= 3'b011;   // fetch word at 0
            cpu_address   <= '0;
            pc            <= '0;
            state         <= FETCH;
          end
        end
        FETCH: begin
          cpu_enable <= 1'b0;
          rd_we      <= 1'b0;
          if (ram_data_out_ready) begin
            ir    <= ram_data_out;
            state <= EXECUTE;
          end
        end
        EXECUTE: begin
          cpu_enable     <= 1'b1;       // fetch of next instruction by default
          cpu_read_type  <= 3'b011;
          cpu_write_type <= '0;
          cpu_address    <= pc_next;
          pc             <= pc_next;
          rd_we          <= wb_en;
          rd_wd          <= wb_val;
          state          <= FETCH;
          if (opcode == OP_LOAD) begin
            cpu_read_type <= {~funct3[2], funct3[1:0] + 2'd1};
            cpu_address   <= rs1_dat + imm_i;
            state         <= LOAD;
          end else if (opcode == OP_STORE) begin
            cpu_read_type  <= '0;
            cpu_write_type <= funct3[1:0] + 2'd1;
            cpu_address    <= rs1_dat + imm_s;
            cpu_data_in    <= rs2_dat;
            state          <= STORE;
          end
        end
        STORE: begin
          cpu_enable <= 1'b0;
          if (!cpu_enable && !ram_busy) begin  // write finished
            cpu_enable     <= 1'b1;
            cpu_read_type  <= 3'b011;
            cpu_write_type <= '0;
            cpu_address    <= pc;
            state          <= FETCH;
          end
        end
        LOAD: begin
          cpu_enable <= 1'b0;
          if (ram_data_out_ready) begin
            rd_wd <= ram_data_out;     // already sized by ramio
            rd_we <= 1'b1;
            state <= LOAD_DONE;
          end
        end
        LOAD_DONE: begin
          rd_we         <= 1'b0;
          cpu_enable    <= 1'b1;
          cpu_read_type <= 3'b011;
          cpu_address   <= pc;
          state         <= FETCH;
        end
        default: state <= IDLE;
      endcase
    end
  end

  reg_file regs0 (
    .clk     (clk),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (rd),
    .rd_wd   (rd_wd),
    .rd_we   (rd_we),
    .rs1_dat (rs1_dat),
    .rs2_dat (rs2_dat)
  );

  a_one_kind: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_enable |-> ((cpu_read_type != '0) ^ (cpu_write_type != '0)));

endmodule

`default_nettype wire

// ==== src/ramio.sv ====
/*
  Memory port: requester select, byte-addressed RAM with sized
  and sign-extended access, and the memory-mapped output register.
*/
`timescale 1ns/10ps
`default_nettype none

module ramio #(
  parameter int unsigned RAM_WORDS = 256
) (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           boot_done,
  input  wire logic           boot_enable,
  input  wire rv_pkg::wtype_t boot_write_type,
  input  wire rv_pkg::word_t  boot_address,
  input  wire rv_pkg::word_t  boot_data_in,
  input  wire logic           cpu_enable,
  input  wire rv_pkg::rtype_t cpu_read_type,
  input  wire rv_pkg::wtype_t cpu_write_type,
  input  wire rv_pkg::word_t  cpu_address,
  input  wire rv_pkg::word_t  cpu_data_in,
  output rv_pkg::word_t       ram_data_out,
  output logic                ram_data_out_ready,
  output logic                ram_busy,
  output rv_pkg::word_t       io_data,
  output logic                io_strobe
);
  import rv_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  word_t   mem [RAM_WORDS];
  logic    sel_en;
  rtype_t  sel_rt;
  wtype_t  sel_wt;
  word_t   sel_addr;
  word_t   sel_data;
  logic    [AW-1:0] sel_idx;
  logic    [1:0] sel_size;
  logic    is_io;
  word_t   rd_word;
  logic    [7:0] rd_byte;
  logic    [15:0] rd_half;
  word_t   rd_sized;

  // loader owns the port until boot_done
  assign sel_en   = boot_done ? cpu_enable     : boot_enable;
  assign sel_rt   = boot_done ? cpu_read_type  : '0;
  assign sel_wt   = boot_done ? cpu_write_type : boot_write_type;
  assign sel_addr = boot_done ? cpu_address    : boot_address;
  assign sel_data = boot_done ? cpu_data_in    : boot_data_in;
  assign sel_idx  = sel_addr[AW+1:2];
  assign sel_size = (sel_wt != '0) ? sel_wt : sel_rt[1:0];
  assign is_io    = sel_addr == IO_ADDR;

  always_comb begin
    rd_word = mem[sel_idx];
    rd_byte = rd_word[8*sel_addr[1:0] +: 8];
    rd_half = rd_word[16*sel_addr[1] +: 16];
    case (sel_rt[1:0])
      2'd1:    rd_sized = {{24{sel_rt[2] & rd_byte[7]}}, rd_byte};
      2'd2:    rd_sized = {{16{sel_rt[2] & rd_half[15]}}, rd_half};
      default: rd_sized = rd_word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (sel_en && !is_io) begin
      case (sel_wt)
        2'd1: mem[sel_idx][8*sel_addr[1:0] +: 8]  <= sel_data[7:0];
        2'd2: mem[sel_idx][16*sel_addr[1] +: 16]  <= sel_data[15:0];
        2'd3: mem[sel_idx]                        <= sel_data;
        default: ;
      endcase
    end
    if (sel_en && sel_rt != '0) ram_data_out <= rd_sized;
    if (sel_en && sel_wt != '0 && is_io) io_data <= sel_data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_busy           <= 1'b0;
      ram_data_out_ready <= 1'b0;
      io_strobe          <= 1'b0;
    end else begin
      ram_busy           <= sel_en && sel_wt != '0;
      ram_data_out_ready <= sel_en && sel_rt != '0;
      io_strobe          <= sel_en && sel_wt != '0 && is_io;
    end
  end

  a_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    sel_en |-> ((sel_size != 2'd2 || !sel_addr[0]) &&
                (sel_size != 2'd3 || sel_addr[1:0] == 2'b00)));

endmodule

`default_nettype wire

// ==== src/rv_soc.sv ====
/*
  SoC top level: flash boot loader, rv32i core and memory port.
*/
`timescale 1ns/10ps
`default_nettype none

module rv_soc #(
  parameter int unsigned STARTUP_WAIT = 1000000,
  parameter int unsigned BOOT_BYTES   = 1024,
  parameter int unsigned RAM_WORDS    = 256
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  output logic          flash_clk,
  output logic          flash_mosi,
  output logic          flash_cs,
  input  wire logic     flash_miso,
  output rv_pkg::word_t io_data,
  output logic          io_strobe
);
  import rv_pkg::*;

  logic   boot_enable;
  wtype_t boot_write_type;
  word_t  boot_address;
  word_t  boot_data_in;
  logic   boot_done;
  logic   cpu_enable;
  rtype_t cpu_read_type;
  wtype_t cpu_write_type;
  word_t  cpu_address;
  word_t  cpu_data_in;
  word_t  ram_data_out;
  logic   ram_data_out_ready;
  logic   ram_busy;

  flash_boot #(
    .STARTUP_WAIT (STARTUP_WAIT),
    .BOOT_BYTES   (BOOT_BYTES)
  ) boot0 (
    .clk             (clk),
    .rst_n           (rst_n),
    .flash_miso      (flash_miso),
    .ram_busy        (ram_busy),
    .flash_clk       (flash_clk),
    .flash_mosi      (flash_mosi),
    .flash_cs        (flash_cs),
    .boot_enable     (boot_enable),
    .boot_write_type (boot_write_type),
    .boot_address    (boot_address),
    .boot_data_in    (boot_data_in),
    .boot_done       (boot_done)
  );

  rv_core core0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .boot_done          (boot_done),
    .ram_data_out       (ram_data_out),
    .ram_data_out_ready (ram_data_out_ready),
    .ram_busy           (ram_busy),
    .cpu_enable         (cpu_enable),
    .cpu_read_type      (cpu_read_type),
    .cpu_write_type     (cpu_write_type),
    .cpu_address        (cpu_address),
    .cpu_data_in        (cpu_data_in)
  );

  ramio #(
    .RAM_WORDS (RAM_WORDS)
  ) ramio0 (
    .clk                (clk),
    .rst_n              (rst_n),
    .boot_done          (boot_done),
    .boot_enable        (boot_enable),
    .boot_write_type    (boot_write_type),
    .boot_address       (boot_address),
    .boot_data_in       (boot_data_in),
    .cpu_enable         (cpu_enable),
    .cpu_read_type      (cpu_read_type),
    .cpu_write_type     (cpu_write_type),
    .cpu_address        (cpu_address),
    .cpu_data_in        (cpu_data_in),
    .ram_data_out       (ram_data_out),
    .ram_data_out_ready (ram_data_out_ready),
    .ram_busy           (ram_busy),
    .io_data            (io_data),
    .io_strobe          (io_strobe)
  );

endmodule

`default_nettype wire

// ==== test/spi_flash_model.sv ====
/*
  Behavioral SPI flash: answers read command 3 from a loadable
  byte array, data shifted out MSB first.
*/
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model #(
  parameter int unsigned MEM_BYTES = 256
) (
  input  wire logic flash_clk,
  input  wire logic flash_mosi,
  input  wire logic flash_cs,
  output logic      flash_miso
);

  logic [7:0]  mem [MEM_BYTES];  // flash image loaded by the testbench
  logic [31:0] cmd_addr;         // command byte then 24-bit address
  logic [7:0]  cur_byte;
  int unsigned bit_cnt;          // clock edges seen in this transaction
  int unsigned rd_idx;

  initial begin
    flash_miso = 1'b0;
    cmd_addr   = '0;
    bit_cnt    = 0;
  end

  // chip select low starts a transaction
  always @(negedge flash_cs) begin
    bit_cnt  = 0;
    cmd_addr = '0;
  end

  always @(posedge flash_clk) begin
    if (flash_cs == 1'b0) begin
      if (bit_cnt < 32) cmd_addr = {cmd_addr[30:0], flash_mosi};  // mosi taken on rise
      bit_cnt = bit_cnt + 1;
    end
  end

  // next read bit goes out on the falling edge
  always @(negedge flash_clk) begin
    if (flash_cs == 1'b0 && bit_cnt >= 32 && cmd_addr[31:24] == 8'h03) begin
      rd_idx     = bit_cnt - 32;
      cur_byte   = mem[(cmd_addr[23:0] + rd_idx / 8) % MEM_BYTES];
      flash_miso <= cur_byte[7 - rd_idx % 8];
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_rv_soc.sv ====
/*
  Testbench of the rv32i SoC: instruction encoders, a table of programs
  with expected output values, flash boot per entry and io_data checks.
*/
`timescale 1ns/10ps
`default_nettype none

module tb_rv_soc;
  import rv_pkg::*;

  localparam int STARTUP_WAIT = 16;
  localparam int BOOT_BYTES   = 256;
  localparam int RAM_WORDS    = 256;
  localparam int PROG_WORDS   = 64;
  localparam int MAX_TESTS    = 32;
  localparam int BOOT_CYCLES  = STARTUP_WAIT + 2 * (32 + 8 * BOOT_BYTES) + 2 * BOOT_BYTES / 4;

  logic  clk;
  logic  rst_n;
  logic  flash_clk;
  logic  flash_mosi;
  logic  flash_cs;
  logic  flash_miso;
  word_t io_data;
  logic  io_strobe;

  string      test_name [MAX_TESTS];
  word_t      prog      [MAX_TESTS][PROG_WORDS];
  int         prog_len  [MAX_TESTS];
  word_t      expected  [MAX_TESTS];
  int         num_tests;
  logic       table_ready;
  int         seed;
  logic [7:0] shadow [8];   // expected bytes at 0x200..0x207

  rv_soc #(
    .STARTUP_WAIT (STARTUP_WAIT),
    .BOOT_BYTES   (BOOT_BYTES),
    .RAM_WORDS    (RAM_WORDS)
  ) dut0 (
    .clk        (clk),
    .rst_n      (rst_n),
    .flash_clk  (flash_clk),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .flash_miso (flash_miso),
    .io_data    (io_data),
    .io_strobe  (io_strobe)
  );

  spi_flash_model #(
    .MEM_BYTES (BOOT_BYTES)
  ) flash0 (
    .flash_clk  (flash_clk),
    .flash_mosi (flash_mosi),
    .flash_cs   (flash_cs),
    .flash_miso (flash_miso)
  );

  always #4 clk = ~clk;

  function automatic word_t r_type(int f7, int f3, int rd, int rs1, int rs2);
    return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_REG};
  endfunction

  function automatic word_t i_type(logic [6:0] op, int f3, int rd, int rs1, int imm);
    return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), op};
  endfunction

  function automatic word_t s_type(int f3, int rs2, int rs1, int imm);
    logic [11:0] m;
    m = 12'(imm);
    return {m[11:5], 5'(rs2), 5'(rs1), 3'(f3), m[4:0], OP_STORE};
  endfunction

  function automatic word_t b_type(int f3, int rs1, int rs2, int off);
    logic [12:0] o;
    o = 13'(off);
    return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], OP_BRANCH};
  endfunction

  function automatic word_t u_type(logic [6:0] op, int rd, int imm);
    return {20'(imm), 5'(rd), op};
  endfunction

  function automatic word_t j_type(int rd, int off);
    logic [20:0] o;
    o = 21'(off);
    return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OP_JAL};
  endfunction

  task automatic emit(word_t instr);
    prog[num_tests][prog_len[num_tests]] = instr;
    prog_len[num_tests]++;
  endtask

  task automatic open_test(string name);
    test_name[num_tests] = name;
    prog_len[num_tests]  = 0;
  endtask

  // result register goes to the output register, then spin
  task automatic close_test(int rs, word_t exp);
    emit(s_type(2, rs, 0, int'(IO_ADDR)));
    emit(j_type(0, 0));
    expected[num_tests] = exp;
    num_tests++;
  endtask

  task automatic load_imm(int rd, word_t v);
    word_t hi;
    hi = v + 32'h800;   // compensates the sign of the low 12 bits
    emit(u_type(OP_LUI, rd, int'(hi >> 12)));
    emit(i_type(OP_IMM, 0, rd, rd, v));
  endtask

  task automatic shadow_store(int off, int size, word_t val);
    for (int i = 0; i < size; i++) shadow[off + i] = val[8*i +: 8];
  endtask

  function automatic word_t shadow_load(int off, int size, bit sext);
    word_t v;
    v = '0;
    for (int i = 0; i < size; i++) v[8*i +: 8] = shadow[off + i];
    if (sext && size == 1) v = {{24{v[7]}}, v[7:0]};
    if (sext && size == 2) v = {{16{v[15]}}, v[15:0]};
    return v;
  endfunction

  task automatic add_alu_test(string name, int f7, int f3, word_t a, word_t b, word_t exp);
    open_test(name);
    load_imm(1, a);
    load_imm(2, b);
    emit(r_type(f7, f3, 3, 1, 2));
    close_test(3, exp);
  endtask

  task automatic add_mem_test(string name, word_t w0, word_t w1, word_t wb);
    word_t r_lb;
    word_t r_lbu;
    word_t r_lh;
    word_t r_lhu;
    word_t r_lw;
    open_test(name);
    load_imm(1, w0);
    load_imm(2, w1);
    load_imm(3, wb);
    emit(s_type(2, 1, 0, 'h200));             // sw
    emit(s_type(2, 2, 0, 'h204));
    emit(s_type(0, 3, 0, 'h201));             // sb
    emit(s_type(1, 3, 0, 'h206));             // sh
    emit(i_type(OP_LOAD, 0, 4, 0, 'h203));    // lb
    emit(i_type(OP_LOAD, 4, 5, 0, 'h201));    // lbu
    emit(i_type(OP_LOAD, 1, 6, 0, 'h206));    // lh
    emit(i_type(OP_LOAD, 5, 7, 0, 'h200));    // lhu
    emit(i_type(OP_LOAD, 2, 8, 0, 'h204));    // lw
    emit(r_type(0, 0, 9, 4, 5));
    emit(r_type(0, 4, 9, 9, 6));
    emit(r_type(0, 0, 9, 9, 7));
    emit(r_type(0, 4, 9, 9, 8));
    shadow_store(0, 4, w0);
    shadow_store(4, 4, w1);
    shadow_store(1, 1, wb);
    shadow_store(6, 2, wb);
    r_lb  = shadow_load(3, 1, 1'b1);
    r_lbu = shadow_load(1, 1, 1'b0);
    r_lh  = shadow_load(6, 2, 1'b1);
    r_lhu = shadow_load(0, 2, 1'b0);
    r_lw  = shadow_load(4, 4, 1'b0);
    close_test(9, ((((r_lb + r_lbu) ^ r_lh) + r_lhu) ^ r_lw));
  endtask

  // sum 1..n where bge and bgeu count down to 1
  task automatic add_branch_test(string name, int f3, int n);
    bit down;
    down = (f3 == 5 || f3 == 7);
    open_test(name);
    emit(i_type(OP_IMM, 0, 1, 0, 0));
    emit(i_type(OP_IMM, 0, 2, 0, down ? n : 1));
    emit(i_type(OP_IMM, 0, 3, 0, down ? 1 : n + 1));
    emit(r_type(0, 0, 1, 1, 2));              // loop at 12
    emit(i_type(OP_IMM, 0, 2, 2, down ? -1 : 1));
    if (f3 == 0) begin
      emit(b_type(0, 2, 3, 8));               // beq leaves the loop
      emit(j_type(0, -12));
    end else begin
      emit(b_type(f3, 2, 3, -8));
    end
    close_test(1, n * (n + 1) / 2);
  endtask

  task automatic add_jump_test(string name, int u1, int u2);
    open_test(name);
    emit(u_type(OP_LUI, 1, u1));              // 0
    emit(u_type(OP_AUIPC, 2, u2));            // 4
    emit(j_type(5, 20));                      // 8, link 12, to 28
    emit(r_type(0, 0, 3, 1, 2));              // 12
    emit(r_type(0, 0, 3, 3, 5));
    emit(r_type(0, 0, 3, 3, 6));
    emit(j_type(7, 8));                       // 24, link 28, to 32
    emit(i_type(OP_JALR, 0, 6, 5, 1));        // 28, link 32, target bit 0 dropped
    emit(r_type(0, 0, 3, 3, 7));              // 32
    close_test(3, (word_t'(u1) << 12) + 32'd4 + (word_t'(u2) << 12) +
                  32'd12 + 32'd32 + 32'd28);
  endtask

  task automatic build_table();
    word_t a;
    word_t b;
    int    imm;
    int    sh;
    for (int k = 0; k < 10; k++) begin
      a = $random(seed);
      b = $random(seed);
      case (k)
        0: add_alu_test("alu_add", 'h00, 0, a, b, a + b);
        1: add_alu_test("alu_sub", 'h20, 0, a, b, a - b);
        2: add_alu_test("alu_xor", 'h00, 4, a, b, a ^ b);
        3: add_alu_test("alu_or", 'h00, 6, a, b, a | b);
        4: add_alu_test("alu_and", 'h00, 7, a, b, a & b);
        5: add_alu_test("alu_slt", 'h00, 2, a, b, ($signed(a) < $signed(b)) ? 1 : 0);
        6: add_alu_test("alu_sltu", 'h00, 3, a, b, (a < b) ? 1 : 0);
        7: add_alu_test("alu_sll", 'h00, 1, a, b, a << b[4:0]);
        8: add_alu_test("alu_srl", 'h00, 5, a, b, a >> b[4:0]);
        default: add_alu_test("alu_sra", 'h20, 5, a, b, $signed(a) >>> b[4:0]);
      endcase
    end
    a   = $random(seed);
    imm = $random(seed) % 2048;
    open_test("alu_addi");
    load_imm(1, a);
    emit(i_type(OP_IMM, 0, 3, 1, imm));
    close_test(3, a + imm);
    add_mem_test("mem_sized", $random(seed), $random(seed), $random(seed));
    add_mem_test("mem_sign", $random(seed) | 32'h8080_8080, $random(seed) | 32'h8080_8080,
                 $random(seed) | 32'h0000_8080);  // negative bytes and halves
    add_branch_test("br_beq", 0, 3 + $unsigned($random(seed)) % 18);
    add_branch_test("br_bne", 1, 3 + $unsigned($random(seed)) % 18);
    add_branch_test("br_blt", 4, 3 + $unsigned($random(seed)) % 18);
    add_branch_test("br_bge", 5, 3 + $unsigned($random(seed)) % 18);
    add_branch_test("br_bltu", 6, 3 + $unsigned($random(seed)) % 18);
    add_branch_test("br_bgeu", 7, 3 + $unsigned($random(seed)) % 18);
    add_jump_test("jump_link_a", $random(seed) & 'hFFFFF, $random(seed) & 'hFFFFF);
    add_jump_test("jump_link_b", $random(seed) & 'hFFFFF, $random(seed) & 'hFFFFF);
    open_test("x0_ignored");
    emit(i_type(OP_IMM, 0, 0, 0, 123));
    emit(i_type(OP_IMM, 0, 1, 0, 5));
    emit(r_type(0, 0, 0, 1, 1));
    emit(u_type(OP_LUI, 0, 'hABCDE));
    emit(r_type(0, 0, 2, 0, 1));
    close_test(2, 5);
    open_test("imm_edges");
    emit(i_type(OP_IMM, 0, 1, 0, -2048));
    emit(i_type(OP_IMM, 0, 2, 0, 2047));
    load_imm(3, 'hA00);                       // 0x200 + 2048
    emit(i_type(OP_IMM, 0, 5, 0, 'h204 - 2047));
    emit(s_type(2, 1, 3, -2048));
    emit(s_type(2, 2, 5, 2047));
    emit(i_type(OP_LOAD, 2, 6, 3, -2048));
    emit(i_type(OP_LOAD, 2, 7, 5, 2047));
    emit(r_type('h20, 0, 8, 6, 7));
    close_test(8, -2048 - 2047);
    a   = $random(seed);
    imm = $random(seed) % 2048;
    open_test("sltiu");
    load_imm(1, a);
    emit(i_type(OP_IMM, 3, 3, 1, imm));
    close_test(3, (a < word_t'(imm)) ? 1 : 0);
    a  = $random(seed) | 32'h8000_0000;
    sh = $random(seed) & 31;
    open_test("srai");
    load_imm(1, a);
    emit(i_type(OP_IMM, 5, 3, 1, 'h400 + sh));
    close_test(3, $signed(a) >>> sh);
  endtask

  task automatic check(string name, word_t exp, word_t act);
    if (act !== exp) begin
      $display("FAIL %0s: expected %h, actual %h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic run_test(int t);
    word_t w;
    @(negedge clk);
    rst_n = 1'b0;
    for (int i = 0; i < BOOT_BYTES; i++) begin
      w = (i / 4 < prog_len[t]) ? prog[t][i / 4] : '0;
      flash0.mem[i] = w[8*(i % 4) +: 8];   // little-endian image
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    while (!io_strobe) @(negedge clk);
    check(test_name[t], expected[t], io_data);
    check({test_name[t], " flash_cs"}, 32'd1, word_t'(flash_cs));
    $display("ok %0s io_data=%h", test_name[t], io_data);
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    seed        = 32'h5ac3;
    num_tests   = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    for (int t = 0; t < num_tests; t++) run_test(t);
    $display("Simulation completed successfully");
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (num_tests * (BOOT_CYCLES + 4000)) @(posedge clk);
    $display("timeout, io_strobe did not arrive within the cycle limit");
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== rv_soc.f ====
src/rv_pkg.sv
src/flash_boot.sv
src/reg_file.sv
src/rv_core.sv
src/ramio.sv
src/rv_soc.sv
test/spi_flash_model.sv
test/tb_rv_soc.sv

// ==== Bender.yml ====
package:
  name: rv_soc

sources:
  - src/rv_pkg.sv
  - src/flash_boot.sv
  - src/reg_file.sv
  - src/rv_core.sv
  - src/ramio.sv
  - src/rv_soc.sv
  - target: test
    files:
      - test/spi_flash_model.sv
      - test/tb_rv_soc.sv
